// File: logic/aui_macros.svh
`ifndef AUI_MACROS_SVH
`define AUI_MACROS_SVH

// Lane geometry of the receive side
`define AUI_LANES      16
`define AUI_LANE_WIDTH 1360
`define AUI_AM_WIDTH   120

`define AUI_AM_PERIOD  8191   // Counter value seen at every sync after the first

// Markers in received bit order by logical lane
`define AUI_AM_LANE_0  120'hF37101260C8EFED9D9B565B6264A9A
`define AUI_AM_LANE_1  120'h7EDE5A988121A567D9B56504264A9A
`define AUI_AM_LANE_2  120'h56F33E01A90CC1FED9B56546264A9A
`define AUI_AM_LANE_3  120'hD080867B2F7F7984D9B5655A264A9A
`define AUI_AM_LANE_4  120'hF2512AE60DAED519D9B565E1264A9A
`define AUI_AM_LANE_5  120'hD14F12B12EB0ED4ED9B565F2264A9A
`define AUI_AM_LANE_6  120'hA19C42115E63BDEED9B5653D264A9A
`define AUI_AM_LANE_7  120'h5B76D6CDA4892932D9B56522264A9A
`define AUI_AM_LANE_8  120'h7573E1608A8C1E9FD9B56560264A9A
`define AUI_AM_LANE_9  120'h3CC4715DC33B8EA2D9B5656B264A9A
`define AUI_AM_LANE_10 120'hD8EB95FB27146A04D9B565FA264A9A
`define AUI_AM_LANE_11 120'h3866228EC799DD71D9B5656C264A9A
`define AUI_AM_LANE_12 120'h95F6A2A46A095D5BD9B56518264A9A
`define AUI_AM_LANE_13 120'hC39731333C68CECCD9B56514264A9A
`define AUI_AM_LANE_14 120'hA6FBCA4E590435B1D9B565D0264A9A
`define AUI_AM_LANE_15 120'h79BAA6A986455956D9B565B4264A9A

`endif

// File: logic/aui_pkg.sv
`include "aui_macros.svh"

package aui_pkg;

    // One lane word as delivered per cycle
    typedef logic [`AUI_LANE_WIDTH-1:0] lane_word_t;

    // Marker sits in the low bits of a lane word
    typedef logic [`AUI_AM_WIDTH-1:0] am_t;

    typedef logic [3:0] lane_idx_t;             // Physical or logical lane number

    typedef logic [`AUI_LANES-1:0] lane_mask_t; // One bit per lane

    // Cycles since last sync, sized to hold the AM period
    typedef logic [12:0] gap_count_t;

endpackage

// File: logic/am_capture.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module am_capture
    import aui_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  lane_word_t [`AUI_LANES-1:0]      i_lane_data,
    input  lane_mask_t                       i_lane_sync,
    output lane_word_t [`AUI_LANES-1:0]      o_cap_data,
    output lane_mask_t                       o_cap_sync
);

    // Input stage that cuts the marker compare away from the pins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cap_sync <= '0;
            for (int l = 0; l < `AUI_LANES; l++) begin
                o_cap_data[l] <= '0;
            end
        end else begin
            o_cap_sync <= i_lane_sync;     // Strobe stays aligned with its word
            for (int l = 0; l < `AUI_LANES; l++) begin
                o_cap_data[l] <= i_lane_data[l];
            end
        end
    end

endmodule

// File: logic/am_matcher.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module am_matcher
    import aui_pkg::*;
(
    input  lane_word_t [`AUI_LANES-1:0]      i_cap_data,
    input  lane_mask_t                       i_cap_sync,
    output lane_idx_t  [`AUI_LANES-1:0]      o_am_id,
    output lane_mask_t                       o_am_bad,
    output logic                             o_pattern_ok
);

    // Standard marker table by logical lane
    localparam am_t am_table [`AUI_LANES] = '{
        `AUI_AM_LANE_0,  `AUI_AM_LANE_1,  `AUI_AM_LANE_2,  `AUI_AM_LANE_3,
        `AUI_AM_LANE_4,  `AUI_AM_LANE_5,  `AUI_AM_LANE_6,  `AUI_AM_LANE_7,
        `AUI_AM_LANE_8,  `AUI_AM_LANE_9,  `AUI_AM_LANE_10, `AUI_AM_LANE_11,
        `AUI_AM_LANE_12, `AUI_AM_LANE_13, `AUI_AM_LANE_14, `AUI_AM_LANE_15
    };

    lane_mask_t covered;    // Logical lanes claimed by some physical lane

    always_comb begin
        lane_idx_t id;
        logic      hit;
        am_t       rx_am;

        covered = '0;
        for (int p = 0; p < `AUI_LANES; p++) begin
            id    = '0;
            hit   = 1'b0;
            rx_am = i_cap_data[p][`AUI_AM_WIDTH-1:0];

            // Sixteen wide compares per physical lane
            for (int l = 0; l < `AUI_LANES; l++) begin
                if (rx_am == am_table[l]) begin
                    id  = lane_idx_t'(l);
                    hit = 1'b1;
                end
            end

            o_am_id[p]  = i_cap_sync[p] ? id : '0;
            o_am_bad[p] = i_cap_sync[p] && !hit;   // Sync without a known marker

            if (i_cap_sync[p] && hit) begin
                covered[id] = 1'b1;
            end
        end
    end

    // Sixteen lanes covering sixteen ids means a permutation
    assign o_pattern_ok = (&i_cap_sync) && !(|o_am_bad) && (&covered);

endmodule

// File: logic/lane_error_monitor.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module lane_error_monitor
    import aui_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lane_mask_t i_cap_sync,
    input  lane_mask_t i_am_bad,
    output lane_mask_t o_lane_error
);

    localparam gap_count_t am_gap = gap_count_t'(`AUI_AM_PERIOD);

    gap_count_t gap_cnt [`AUI_LANES];   // Cycles since last sync per lane
    lane_mask_t seen_sync;              // Lane had its first sync

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_sync    <= '0;
            o_lane_error <= '0;
            for (int l = 0; l < `AUI_LANES; l++) begin
                gap_cnt[l] <= '0;
            end
        end else begin
            for (int l = 0; l < `AUI_LANES; l++) begin
                if (i_cap_sync[l]) begin
                    gap_cnt[l]   <= '0;
                    seen_sync[l] <= 1'b1;
                    // First sync only starts the count
                    if (seen_sync[l] && gap_cnt[l] != am_gap) begin
                        o_lane_error[l] <= 1'b1;
                    end
                end else begin
                    gap_cnt[l] <= gap_cnt[l] + gap_count_t'(1);
                end

                if (i_am_bad[l]) begin
                    o_lane_error[l] <= 1'b1;   // Sticky until reset
                end
            end
        end
    end

endmodule

// File: logic/lane_mapper.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module lane_mapper
    import aui_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  lane_word_t [`AUI_LANES-1:0]      i_cap_data,
    input  lane_idx_t  [`AUI_LANES-1:0]      i_am_id,
    input  logic                             i_pattern_ok,
    output lane_word_t [`AUI_LANES-1:0]      o_lane_data,
    output logic                             o_valid_pattern,
    output logic                             o_locked
);

    lane_idx_t lane_map [`AUI_LANES];   // Logical lane to physical lane
    lane_idx_t new_map  [`AUI_LANES];
    lane_idx_t use_map  [`AUI_LANES];
    logic      take_map;

    assign take_map = i_pattern_ok && !o_locked;

    // Invert the per-lane ids into a logical-to-physical map
    always_comb begin
        new_map = lane_map;
        for (int p = 0; p < `AUI_LANES; p++) begin
            new_map[i_am_id[p]] = lane_idx_t'(p);
        end
    end

    // Fresh map already steers the words of the locking cycle
    assign use_map = take_map ? new_map : lane_map;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid_pattern <= 1'b0;
            o_locked        <= 1'b0;
            for (int l = 0; l < `AUI_LANES; l++) begin
                lane_map[l]    <= lane_idx_t'(l);   // Identity until lock
                o_lane_data[l] <= '0;
            end
        end else begin
            o_valid_pattern <= i_pattern_ok;
            if (take_map) begin
                o_locked <= 1'b1;
                lane_map <= new_map;    // Only the first good pattern counts
            end
            // Identity map before lock passes words straight through
            for (int l = 0; l < `AUI_LANES; l++) begin
                o_lane_data[l] <= i_cap_data[use_map[l]];
            end
        end
    end

endmodule

// File: logic/aui_checker.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module aui_checker
    import aui_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  lane_word_t [`AUI_LANES-1:0]      i_lane_data,     // By physical lane
    input  lane_mask_t                       i_lane_sync,
    output lane_word_t [`AUI_LANES-1:0]      o_lane_data,     // By logical lane
    output logic                             o_valid_pattern,
    output logic                             o_locked,
    output lane_mask_t                       o_lane_error
);

    lane_word_t [`AUI_LANES-1:0] cap_data;
    lane_mask_t                  cap_sync;
    lane_idx_t  [`AUI_LANES-1:0] am_id;
    lane_mask_t                  am_bad;
    logic                        pattern_ok;

    am_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .i_lane_data (i_lane_data),
        .i_lane_sync (i_lane_sync),
        .o_cap_data  (cap_data),
        .o_cap_sync  (cap_sync)
    );

    // Combinational results are valid one cycle after the pins
    am_matcher u_matcher (
        .i_cap_data   (cap_data),
        .i_cap_sync   (cap_sync),
        .o_am_id      (am_id),
        .o_am_bad     (am_bad),
        .o_pattern_ok (pattern_ok)
    );

    lane_error_monitor u_error_monitor (
        .clk          (clk),
        .rst          (rst),
        .i_cap_sync   (cap_sync),
        .i_am_bad     (am_bad),
        .o_lane_error (o_lane_error)
    );

    lane_mapper u_mapper (
        .clk             (clk),
        .rst             (rst),
        .i_cap_data      (cap_data),
        .i_am_id         (am_id),
        .i_pattern_ok    (pattern_ok),
        .o_lane_data     (o_lane_data),
        .o_valid_pattern (o_valid_pattern),
        .o_locked        (o_locked)
    );

endmodule

// File: bench/aui_checker_tb.sv
`timescale 1ns/1ps

`include "aui_macros.svh"

module aui_checker_tb
    import aui_pkg::*;
();

    localparam int am_cycles  = `AUI_AM_PERIOD + 1;     // Sync to sync distance
    localparam int max_cycles = 5 * am_cycles + 4040;   // Five periods plus margin
    localparam int late_lane  = 5;
    localparam int bad_lane   = 11;

    // Standard markers by logical lane
    localparam am_t markers [`AUI_LANES] = '{
        `AUI_AM_LANE_0,  `AUI_AM_LANE_1,  `AUI_AM_LANE_2,  `AUI_AM_LANE_3,
        `AUI_AM_LANE_4,  `AUI_AM_LANE_5,  `AUI_AM_LANE_6,  `AUI_AM_LANE_7,
        `AUI_AM_LANE_8,  `AUI_AM_LANE_9,  `AUI_AM_LANE_10, `AUI_AM_LANE_11,
        `AUI_AM_LANE_12, `AUI_AM_LANE_13, `AUI_AM_LANE_14, `AUI_AM_LANE_15
    };

    logic                        clk = 1'b0;
    logic                        rst;
    lane_word_t [`AUI_LANES-1:0] i_lane_data;
    lane_mask_t                  i_lane_sync;
    lane_word_t [`AUI_LANES-1:0] o_lane_data;
    logic                        o_valid_pattern;
    logic                        o_locked;
    lane_mask_t                  o_lane_error;

    logic [31:0] lfsr_state;
    string       test_name;
    lane_idx_t   perm     [`AUI_LANES];   // Logical marker carried by each physical lane
    lane_idx_t   inv_perm [`AUI_LANES];   // Physical lane of each logical lane
    logic        drive_good;              // This cycle carries a full valid pattern
    lane_mask_t  drive_err;               // Lanes that must flag an error from this cycle
    int          cycle_count = 0;

    // Two-deep history of the driven inputs
    lane_word_t [`AUI_LANES-1:0] hist1_data;
    lane_word_t [`AUI_LANES-1:0] hist2_data;
    logic                        hist1_good;
    logic                        hist2_good;
    lane_mask_t                  hist1_err;
    logic                        exp_locked;
    lane_mask_t                  exp_err;
    lane_word_t [`AUI_LANES-1:0] exp_data;

    aui_checker uut (
        .clk             (clk),
        .rst             (rst),
        .i_lane_data     (i_lane_data),
        .i_lane_sync     (i_lane_sync),
        .o_lane_data     (o_lane_data),
        .o_valid_pattern (o_valid_pattern),
        .o_locked        (o_locked),
        .o_lane_error    (o_lane_error)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic lane_word_t random_word();
        lane_word_t  w;
        logic [31:0] r;
        r = take_bits(32);
        for (int j = 0; j < `AUI_LANE_WIDTH / 16; j++) begin
            w[j*16 +: 16] = 16'(r >> (j % 16)) ^ 16'(j * 40503);
        end
        return w;
    endfunction

    // Fisher-Yates shuffle that rejects draws above the index
    task automatic shuffle_lanes();
        int        j;
        int        nb;
        lane_idx_t t;
        for (int k = 0; k < `AUI_LANES; k++) begin
            perm[k] = lane_idx_t'(k);
        end
        for (int i = `AUI_LANES - 1; i > 0; i--) begin
            nb = 0;
            while ((1 << nb) <= i) begin
                nb++;
            end
            do begin
                j = int'(take_bits(nb));
            end while (j > i);
            t       = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        for (int k = 0; k < `AUI_LANES; k++) begin
            inv_perm[perm[k]] = lane_idx_t'(k);
        end
    endtask

    // Holds one cycle of lane inputs with markers placed by the permutation
    task automatic drive_cycle(input lane_mask_t sync, input lane_mask_t corrupt,
                               input logic good, input lane_mask_t err);
        lane_word_t w;
        am_t        am;
        for (int p = 0; p < `AUI_LANES; p++) begin
            w = random_word();
            if (sync[p]) begin
                am = markers[perm[p]];
                if (corrupt[p]) begin
                    am[0] = ~am[0];   // One flipped bit matches no marker
                end
                w[`AUI_AM_WIDTH-1:0] = am;
            end
            i_lane_data[p] = w;
        end
        i_lane_sync = sync;
        drive_good  = good;
        drive_err   = err;
        @(posedge clk);
        #1;
    endtask

    task automatic report_value(input string what, input lane_word_t expv, input lane_word_t actv);
        $display("ERR %s %s: expected %0h actual %0h", test_name, what, expv, actv);
        $display("TB FAILED");
        $fatal(1, "output mismatch");
    endtask

    function automatic int first_bad_lane();
        for (int k = 0; k < `AUI_LANES; k++) begin
            if (o_lane_data[k] != exp_data[k]) begin
                return k;
            end
        end
        return 0;
    endfunction

    task automatic report_lane_data();
        int k;
        k = first_bad_lane();
        report_value($sformatf("o_lane_data[%0d]", k), exp_data[k], o_lane_data[k]);
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist1_data <= '0;
            hist2_data <= '0;
            hist1_good <= 1'b0;
            hist2_good <= 1'b0;
            hist1_err  <= '0;
            exp_locked <= 1'b0;
            exp_err    <= '0;
        end else begin
            hist1_data <= i_lane_data;
            hist2_data <= hist1_data;
            hist1_good <= drive_good;
            hist2_good <= hist1_good;
            hist1_err  <= drive_err;
            exp_err    <= exp_err | hist1_err;   // Sticky from two cycles after the cause
            if (hist1_good) begin
                exp_locked <= 1'b1;
            end
        end
    end

    // Reordered from the first pulse on and identity before
    always_comb begin
        for (int k = 0; k < `AUI_LANES; k++) begin
            exp_data[k] = hist2_data[exp_locked ? inv_perm[k] : lane_idx_t'(k)];
        end
    end

    // Outputs are stable at the falling edge
    assert property (@(negedge clk) o_valid_pattern == hist2_good)
        else report_value("o_valid_pattern", lane_word_t'(hist2_good),
                          lane_word_t'(o_valid_pattern));
    assert property (@(negedge clk) o_locked == exp_locked)
        else report_value("o_locked", lane_word_t'(exp_locked), lane_word_t'(o_locked));
    assert property (@(negedge clk) o_lane_error == exp_err)
        else report_value("o_lane_error", lane_word_t'(exp_err), lane_word_t'(o_lane_error));
    assert property (@(negedge clk) o_lane_data == exp_data)
        else report_lane_data();

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int         n;
        int         r;
        lane_mask_t sync;
        lane_mask_t corrupt;
        logic       good;
        lane_mask_t err;
        lane_mask_t late_bit;
        lane_mask_t bad_bit;

        late_bit    = lane_mask_t'(1) << late_lane;
        bad_bit     = lane_mask_t'(1) << bad_lane;
        rst         = 1'b1;
        i_lane_data = '0;
        i_lane_sync = '0;
        drive_good  = 1'b0;
        drive_err   = '0;
        test_name   = "reset";
        lfsr_state  = 32'ha074_616a;
        shuffle_lanes();

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "identity";
        repeat (20) begin
            drive_cycle('0, '0, 1'b0, '0);
        end

        for (int c = 0; c < 5 * am_cycles + 9; c++) begin
            n = c / am_cycles;
            r = c % am_cycles;
            if (r == 0) begin
                case (n)
                    0:       test_name = "pattern_lock";
                    4:       test_name = "gap_error";
                    5:       test_name = "bad_marker";
                    default: test_name = "clean_period";
                endcase
            end
            sync    = '0;
            corrupt = '0;
            good    = 1'b0;
            err     = '0;
            if (r == 0 && n <= 3) begin
                sync = '1;
                good = 1'b1;
            end else if (n == 4 && r == 0) begin
                sync = ~late_bit;
            end else if (n == 4 && r == 1) begin
                sync = late_bit;   // One cycle late so the gap exceeds a period
                err  = late_bit;
            end else if (n == 5 && r == 0) begin
                sync    = '1;
                corrupt = bad_bit;
                err     = late_bit | bad_bit;   // Late lane now one cycle early
            end
            drive_cycle(sync, corrupt, good, err);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/aui_pkg.sv
logic/am_capture.sv
logic/am_matcher.sv
logic/lane_error_monitor.sv
logic/lane_mapper.sv
logic/aui_checker.sv
bench/aui_checker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AUI checker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module aui_checker_tb \
    -f sources.f \
    --Mdir obj_dir \
    -o sim_aui_checker
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_aui_checker
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
